// File: source/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Machine-mode CSR addresses.
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MIP         12'h344
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13
`define CSR_MHARTID     12'hF14

// Bit positions shared by mie and mip.
`define MSTATUS_MIE_BIT 3
`define MIE_MSIE_BIT    3
`define MIE_MTIE_BIT    7
`define MIE_MEIE_BIT    11

`define CAUSE_TIMER     32'h8000_0007
`define CAUSE_EXTERNAL  32'h8000_000B
`define CAUSE_ECALL     32'h0000_000B

// Register forms; bit 2 set selects the immediate form.
`define FUNCT3_CSRRW    3'b001
`define FUNCT3_CSRRS    3'b010
`define FUNCT3_CSRRC    3'b011
`define FUNCT3_IMM_BIT  2

`define DEF_VENDORID    32'h0000_0000
`define DEF_ARCHID      32'h0000_0000
`define DEF_IMPID       32'h0000_0001
`define DEF_HARTID      32'h0000_0000

`endif

// File: source/csr_pkg.sv
package csr_pkg;

	// CSR values, PCs and rs1 operands.
	typedef logic [31:0] csr_word_t;

	// CSR address space.
	typedef logic [11:0] csr_index_t;

	// Zicsr operation code from funct3.
	typedef logic [2:0] csr_funct3_t;

	// mcause value; bit 31 flags an interrupt.
	typedef logic [31:0] csr_cause_t;

	// Trap controller states.
	typedef enum logic {
		IRQ_IDLE,
		IRQ_PENDING
	} irq_state_t;

endpackage

// File: source/csr_access_if.sv
`timescale 1ns/10ps

interface csr_access_if import csr_pkg::*; ();

	// Access is a one-cycle level.
	logic access;
	logic write;
	csr_index_t index;
	csr_word_t wdata;

	// Combinational answer from the register file.
	csr_word_t rdata;
	logic illegal;

	modport master (
		output access,
		output write,
		output index,
		output wdata,
		input rdata,
		input illegal
	);

	modport slave (
		input access,
		input write,
		input index,
		input wdata,
		output rdata,
		output illegal
	);

endinterface

// File: source/csr_trap_if.sv
`timescale 1ns/10ps

interface csr_trap_if import csr_pkg::*; ();

	// From the register file.
	logic global_enable;
	logic [2:0] enable_bits;
	csr_word_t mtvec;
	csr_cause_t mcause;

	// From the interrupt controller; bit order is {meip, mtip, msip}.
	logic [2:0] pending_bits;
	logic cause_wr;
	csr_cause_t cause;
	logic epc_wr;
	csr_word_t epc;

	modport file (
		output global_enable,
		output enable_bits,
		output mtvec,
		output mcause,
		input pending_bits,
		input cause_wr,
		input cause,
		input epc_wr,
		input epc
	);

	modport controller (
		input global_enable,
		input enable_bits,
		input mtvec,
		input mcause,
		output pending_bits,
		output cause_wr,
		output cause,
		output epc_wr,
		output epc
	);

endinterface

// File: source/csr_op_unit.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_op_unit import csr_pkg::*; (
	input logic i_csr_valid,
	input csr_funct3_t i_csr_funct3,
	input csr_index_t i_csr_index,
	input logic [4:0] i_rs1_field,
	input csr_word_t i_rs1_value,

	csr_access_if.master csr,

	output csr_word_t o_csr_rdata
);

	logic imm_form;
	logic rs1_zero;
	csr_funct3_t base_op;
	csr_word_t operand;
	csr_word_t new_value;
	logic write_en;

	assign imm_form = i_csr_funct3[`FUNCT3_IMM_BIT];
	assign base_op = {1'b0, i_csr_funct3[1:0]};
	assign rs1_zero = (i_rs1_field == 5'd0);

	// Immediate forms take the zero-extended rs1 field.
	assign operand = imm_form ? {27'd0, i_rs1_field} : i_rs1_value;

	always_comb begin
		new_value = csr.rdata;
		write_en = 1'b0;
		case (base_op)
			`FUNCT3_CSRRW: begin
				new_value = operand;
				write_en = 1'b1;
			end
			`FUNCT3_CSRRS: begin
				new_value = csr.rdata | operand;
				write_en = !rs1_zero;
			end
			`FUNCT3_CSRRC: begin
				new_value = csr.rdata & ~operand;
				write_en = !rs1_zero;
			end
			default: begin
				new_value = csr.rdata;
				write_en = 1'b0;
			end
		endcase
	end

	assign csr.access = i_csr_valid;
	assign csr.write = i_csr_valid && write_en;
	assign csr.index = i_csr_index;
	assign csr.wdata = new_value;

	// Old value goes back to rd.
	assign o_csr_rdata = csr.rdata;

endmodule

// File: source/csr_file.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_file import csr_pkg::*; #(
	parameter csr_word_t VENDORID = `DEF_VENDORID,
	parameter csr_word_t ARCHID = `DEF_ARCHID,
	parameter csr_word_t IMPID = `DEF_IMPID,
	parameter csr_word_t HARTID = `DEF_HARTID
) (
	input logic i_clock,
	input logic i_reset,
	output csr_word_t o_epc,

	csr_access_if.slave csr,
	csr_trap_if.file trap
);

	logic mstatus_mie;
	// {meie, mtie, msie}.
	logic [2:0] mie_bits;
	csr_word_t mtvec;
	csr_word_t mepc;
	csr_cause_t mcause;

	csr_word_t mstatus_image;
	csr_word_t mie_image;
	csr_word_t mip_image;
	logic known;
	logic write_en;

	always_comb begin
		mstatus_image = '0;
		mstatus_image[`MSTATUS_MIE_BIT] = mstatus_mie;

		mie_image = '0;
		mie_image[`MIE_MEIE_BIT] = mie_bits[2];
		mie_image[`MIE_MTIE_BIT] = mie_bits[1];
		mie_image[`MIE_MSIE_BIT] = mie_bits[0];

		// mip uses the mie positions.
		mip_image = '0;
		mip_image[`MIE_MEIE_BIT] = trap.pending_bits[2];
		mip_image[`MIE_MTIE_BIT] = trap.pending_bits[1];
		mip_image[`MIE_MSIE_BIT] = trap.pending_bits[0];
	end

	always_comb begin
		known = 1'b1;
		csr.rdata = '0;
		case (csr.index)
			`CSR_MSTATUS:   csr.rdata = mstatus_image;
			`CSR_MIE:       csr.rdata = mie_image;
			`CSR_MTVEC:     csr.rdata = mtvec;
			`CSR_MEPC:      csr.rdata = mepc;
			`CSR_MCAUSE:    csr.rdata = mcause;
			`CSR_MIP:       csr.rdata = mip_image;
			`CSR_MVENDORID: csr.rdata = VENDORID;
			`CSR_MARCHID:   csr.rdata = ARCHID;
			`CSR_MIMPID:    csr.rdata = IMPID;
			`CSR_MHARTID:   csr.rdata = HARTID;
			default:        known = 1'b0;
		endcase
	end

	// Top two address bits set mark a read-only CSR.
	assign csr.illegal = csr.access &&
		(!known || (csr.write && csr.index[11:10] == 2'b11));
	assign write_en = csr.access && csr.write && !csr.illegal;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie <= 1'b0;
			mie_bits <= 3'b000;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else begin
			if (write_en) begin
				case (csr.index)
					`CSR_MSTATUS: mstatus_mie <= csr.wdata[`MSTATUS_MIE_BIT];
					`CSR_MIE: mie_bits <= {csr.wdata[`MIE_MEIE_BIT],
						csr.wdata[`MIE_MTIE_BIT], csr.wdata[`MIE_MSIE_BIT]};
					`CSR_MTVEC: mtvec <= csr.wdata;
					`CSR_MEPC: mepc <= csr.wdata;
					default: ;
				endcase
			end
			// Trap update overrides a software mepc write.
			if (trap.epc_wr)
				mepc <= trap.epc;
			if (trap.cause_wr)
				mcause <= trap.cause;
		end
	end

	assign trap.global_enable = mstatus_mie;
	assign trap.enable_bits = mie_bits;
	assign trap.mtvec = mtvec;
	assign trap.mcause = mcause;

	assign o_epc = mepc;

endmodule

// File: source/irq_controller.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module irq_controller import csr_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,
	input logic i_irq_dispatched,
	input csr_word_t i_irq_epc,
	output logic o_irq_pending,
	output csr_word_t o_irq_pc,

	csr_trap_if.controller trap
);

	irq_state_t state;
	// {meip, mtip, msip}.
	logic [2:0] pending;
	logic [2:0] request;
	logic [2:0] set_mask;
	logic [2:0] clear_mask;
	logic dispatch_q;
	logic dispatch_rise;
	csr_word_t irq_pc;

	assign request = {i_external_interrupt, i_timer_interrupt, i_ecall};

	// Latch only globally and individually enabled requests.
	assign set_mask = trap.global_enable ? (request & trap.enable_bits) : 3'b000;

	assign dispatch_rise = i_irq_dispatched && !dispatch_q;

	// Timer, then external, then ecall.
	always_comb begin
		trap.cause_wr = 1'b0;
		trap.cause = '0;
		if (state == IRQ_IDLE) begin
			if (pending[1]) begin
				trap.cause_wr = 1'b1;
				trap.cause = `CAUSE_TIMER;
			end else if (pending[2]) begin
				trap.cause_wr = 1'b1;
				trap.cause = `CAUSE_EXTERNAL;
			end else if (pending[0]) begin
				trap.cause_wr = 1'b1;
				trap.cause = `CAUSE_ECALL;
			end
		end
	end

	assign trap.epc_wr = (state == IRQ_PENDING) && dispatch_rise;
	assign trap.epc = i_irq_epc;

	// mcause holds the issued source while a trap is pending.
	always_comb begin
		clear_mask = 3'b000;
		if (trap.epc_wr) begin
			case (trap.mcause)
				`CAUSE_TIMER:    clear_mask = 3'b010;
				`CAUSE_EXTERNAL: clear_mask = 3'b100;
				`CAUSE_ECALL:    clear_mask = 3'b001;
				default:         clear_mask = 3'b000;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IRQ_IDLE;
			pending <= 3'b000;
			dispatch_q <= 1'b0;
		end else begin
			pending <= (pending & ~clear_mask) | set_mask;
			dispatch_q <= i_irq_dispatched;
			case (state)
				IRQ_IDLE:
					if (trap.cause_wr)
						state <= IRQ_PENDING;
				IRQ_PENDING:
					if (trap.epc_wr)
						state <= IRQ_IDLE;
				default:
					state <= IRQ_IDLE;
			endcase
		end
	end

	// Vector captured when the trap is issued.
	always_ff @(posedge i_clock) begin
		if (trap.cause_wr)
			irq_pc <= trap.mtvec;
	end

	assign trap.pending_bits = pending;
	assign o_irq_pending = (state == IRQ_PENDING);
	assign o_irq_pc = irq_pc;

endmodule

// File: source/csr_unit.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_unit import csr_pkg::*; #(
	parameter csr_word_t VENDORID = `DEF_VENDORID,
	parameter csr_word_t ARCHID = `DEF_ARCHID,
	parameter csr_word_t IMPID = `DEF_IMPID,
	parameter csr_word_t HARTID = `DEF_HARTID
) (
	input logic i_clock,
	input logic i_reset,

	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,

	input logic i_csr_valid,
	input csr_funct3_t i_csr_funct3,
	input csr_index_t i_csr_index,
	input logic [4:0] i_rs1_field,
	input csr_word_t i_rs1_value,
	output csr_word_t o_csr_rdata,
	output logic o_csr_illegal,

	output csr_word_t o_epc,

	output logic o_irq_pending,
	output csr_word_t o_irq_pc,
	input logic i_irq_dispatched,
	input csr_word_t i_irq_epc
);

	csr_access_if csr_bus ();
	csr_trap_if trap_bus ();

	csr_op_unit op_unit (
		.i_csr_valid(i_csr_valid),
		.i_csr_funct3(i_csr_funct3),
		.i_csr_index(i_csr_index),
		.i_rs1_field(i_rs1_field),
		.i_rs1_value(i_rs1_value),
		.csr(csr_bus.master),
		.o_csr_rdata(o_csr_rdata)
	);

	csr_file #(
		.VENDORID(VENDORID),
		.ARCHID(ARCHID),
		.IMPID(IMPID),
		.HARTID(HARTID)
	) regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_epc(o_epc),
		.csr(csr_bus.slave),
		.trap(trap_bus.file)
	);

	irq_controller irq_ctrl (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_ecall(i_ecall),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.trap(trap_bus.controller)
	);

	assign o_csr_illegal = csr_bus.illegal;

endmodule

// File: testbench/csr_unit_chk.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_unit_chk import csr_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_csr_valid,
	input csr_funct3_t i_csr_funct3,
	input csr_index_t i_csr_index,
	input logic [4:0] i_rs1_field,
	input csr_word_t i_csr_rdata,
	input logic i_csr_illegal,
	input csr_word_t i_epc,
	input logic i_irq_pending,
	input logic i_irq_dispatched,
	input csr_word_t i_irq_epc
);

	int fail_count = 0;
	logic write_intent;
	logic writable_index;
	logic identity_index;
	csr_word_t identity_value;

	// RW always writes, RS and RC only with a nonzero rs1 field.
	assign write_intent = (i_csr_funct3[1:0] == 2'b01) ||
		(i_csr_funct3[1:0] != 2'b00 && i_rs1_field != 5'd0);

	assign writable_index = i_csr_index inside {`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC,
		`CSR_MEPC, `CSR_MCAUSE, `CSR_MIP};

	always_comb begin
		identity_index = 1'b1;
		identity_value = '0;
		case (i_csr_index)
			`CSR_MVENDORID: identity_value = `DEF_VENDORID;
			`CSR_MARCHID:   identity_value = `DEF_ARCHID;
			`CSR_MIMPID:    identity_value = `DEF_IMPID;
			`CSR_MHARTID:   identity_value = `DEF_HARTID;
			default:        identity_index = 1'b0;
		endcase
	end

	legal_access: assert property (@(posedge i_clock) disable iff (i_reset)
		i_csr_valid && writable_index |-> !i_csr_illegal)
		else begin
			fail_count = fail_count + 1;
			$error("[FAIL] %0t o_csr_illegal got 1 expected 0", $time);
		end

	unknown_index: assert property (@(posedge i_clock) disable iff (i_reset)
		i_csr_valid && !writable_index && !identity_index |-> i_csr_illegal)
		else begin
			fail_count = fail_count + 1;
			$error("[FAIL] %0t o_csr_illegal got 0 expected 1", $time);
		end

	identity_write: assert property (@(posedge i_clock) disable iff (i_reset)
		i_csr_valid && identity_index && write_intent |-> i_csr_illegal)
		else begin
			fail_count = fail_count + 1;
			$error("[FAIL] %0t o_csr_illegal got 0 expected 1", $time);
		end

	identity_read: assert property (@(posedge i_clock) disable iff (i_reset)
		i_csr_valid && identity_index |-> i_csr_rdata == identity_value)
		else begin
			fail_count = fail_count + 1;
			$error("[FAIL] %0t o_csr_rdata got %h expected %h", $time,
				i_csr_rdata, identity_value);
		end

	// First rising edge of the dispatch strobe ends the trap.
	dispatch_done: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_pending && i_irq_dispatched && !$past(i_irq_dispatched) |=>
		!i_irq_pending && i_epc == $past(i_irq_epc))
		else begin
			fail_count = fail_count + 1;
			$error("[FAIL] %0t dispatch did not clear the trap or load o_epc", $time);
		end

	pending_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_pending && !(i_irq_dispatched && !$past(i_irq_dispatched)) |=>
		i_irq_pending)
		else begin
			fail_count = fail_count + 1;
			$error("[FAIL] %0t o_irq_pending fell without a dispatch edge", $time);
		end

endmodule

// File: testbench/csr_unit_tb.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_unit_tb import csr_pkg::*; ();

	// About twice the roughly 225 cycles of the full sequence.
	localparam int CYCLE_LIMIT = 450;
	localparam int RANDOM_OPS = 40;

	logic i_clock;
	logic i_reset;
	logic i_timer_interrupt;
	logic i_external_interrupt;
	logic i_ecall;
	logic i_csr_valid;
	csr_funct3_t i_csr_funct3;
	csr_index_t i_csr_index;
	logic [4:0] i_rs1_field;
	csr_word_t i_rs1_value;
	csr_word_t o_csr_rdata;
	logic o_csr_illegal;
	csr_word_t o_epc;
	logic o_irq_pending;
	csr_word_t o_irq_pc;
	logic i_irq_dispatched;
	csr_word_t i_irq_epc;

	// Writable CSRs as the ISA rules leave them.
	csr_word_t model_mstatus;
	csr_word_t model_mie;
	csr_word_t model_mtvec;
	csr_word_t model_mepc;

	integer seed;
	int checks = 0;
	int errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;
	int cycles = 0;

	csr_unit uut (.*);

	bind csr_unit csr_unit_chk chk (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_csr_valid(i_csr_valid),
		.i_csr_funct3(i_csr_funct3),
		.i_csr_index(i_csr_index),
		.i_rs1_field(i_rs1_field),
		.i_csr_rdata(o_csr_rdata),
		.i_csr_illegal(o_csr_illegal),
		.i_epc(o_epc),
		.i_irq_pending(o_irq_pending),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	always @(posedge i_clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic csr_word_t apply_op(csr_funct3_t op, csr_word_t old_value,
		logic [4:0] field, csr_word_t value);
		csr_word_t operand;
		operand = op[2] ? {27'd0, field} : value;
		case (op[1:0])
			2'b01: return operand;
			2'b10: return old_value | operand;
			2'b11: return old_value & ~operand;
			default: return old_value;
		endcase
	endfunction

	function automatic logic writes(csr_funct3_t op, logic [4:0] field);
		return op[1:0] == 2'b01 || (op[1:0] != 2'b00 && field != 5'd0);
	endfunction

	function automatic csr_word_t model_value(csr_index_t index);
		case (index)
			`CSR_MSTATUS: return model_mstatus;
			`CSR_MIE: return model_mie;
			`CSR_MTVEC: return model_mtvec;
			default: return model_mepc;
		endcase
	endfunction

	// Only mstatus.MIE and the three mie enables exist.
	task automatic set_model(csr_index_t index, csr_word_t value);
		case (index)
			`CSR_MSTATUS: model_mstatus = value & 32'h0000_0008;
			`CSR_MIE: model_mie = value & 32'h0000_0888;
			`CSR_MTVEC: model_mtvec = value;
			default: model_mepc = value;
		endcase
	endtask

	task automatic check_value(string name, csr_word_t got, csr_word_t expected);
		checks++;
		assert (got === expected) else begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic check_flag(string name, logic got, logic expected);
		checks++;
		assert (got === expected) else begin
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic report_test(int number, string name);
		$display("Test %0d %s done: %0d checks, %0d failures", number, name,
			checks - checks_mark, errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	// One-cycle access; outputs sampled at the falling edge.
	task automatic csr_op(csr_funct3_t op, csr_index_t index, logic [4:0] field,
		csr_word_t value, output csr_word_t rdata, output logic illegal);
		@(posedge i_clock);
		i_csr_valid <= 1'b1;
		i_csr_funct3 <= op;
		i_csr_index <= index;
		i_rs1_field <= field;
		i_rs1_value <= value;
		@(negedge i_clock);
		rdata = o_csr_rdata;
		illegal = o_csr_illegal;
		@(posedge i_clock);
		i_csr_valid <= 1'b0;
	endtask

	task automatic write_csr(csr_index_t index, csr_word_t value);
		csr_word_t rdata;
		logic illegal;
		csr_op(`FUNCT3_CSRRW, index, 5'd1, value, rdata, illegal);
		check_flag("o_csr_illegal", illegal, 1'b0);
		set_model(index, value);
	endtask

	task automatic expect_csr(string name, csr_index_t index, csr_word_t expected);
		csr_word_t rdata;
		logic illegal;
		csr_op(`FUNCT3_CSRRS, index, 5'd0, 32'd0, rdata, illegal);
		check_value(name, rdata, expected);
		check_flag("o_csr_illegal", illegal, 1'b0);
	endtask

	task automatic expect_illegal(csr_funct3_t op, csr_index_t index);
		csr_word_t rdata;
		logic illegal;
		csr_op(op, index, 5'd3, 32'hFFFF_FFFF, rdata, illegal);
		check_flag("o_csr_illegal", illegal, 1'b1);
	endtask

	task automatic drive_requests(logic [2:0] bits);
		@(posedge i_clock);
		i_external_interrupt <= bits[2];
		i_timer_interrupt <= bits[1];
		i_ecall <= bits[0];
	endtask

	task automatic wait_pending();
		int waited;
		waited = 0;
		@(negedge i_clock);
		while (!o_irq_pending && waited < 10) begin
			@(negedge i_clock);
			waited++;
		end
		checks++;
		if (!o_irq_pending) begin
			$display("%0t no trap became pending within 10 cycles", $time);
			errors++;
		end
	endtask

	task automatic dispatch(csr_word_t pc);
		@(posedge i_clock);
		i_irq_dispatched <= 1'b1;
		i_irq_epc <= pc;
		@(posedge i_clock);
		i_irq_dispatched <= 1'b0;
		@(negedge i_clock);
		check_flag("o_irq_pending", o_irq_pending, 1'b0);
		check_value("o_epc", o_epc, pc);
		model_mepc = pc;
	endtask

	task automatic take_trap(csr_cause_t cause);
		csr_word_t saved_pc;
		saved_pc = $random(seed);
		wait_pending();
		check_value("o_irq_pc", o_irq_pc, model_mtvec);
		expect_csr("mcause", `CSR_MCAUSE, cause);
		dispatch(saved_pc);
	endtask

	task automatic random_ops();
		csr_index_t index;
		csr_funct3_t op;
		logic [4:0] field;
		csr_word_t value;
		csr_word_t old_value;
		csr_word_t rdata;
		logic illegal;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			case ($unsigned($random(seed)) % 4)
				0: index = `CSR_MSTATUS;
				1: index = `CSR_MIE;
				2: index = `CSR_MTVEC;
				default: index = `CSR_MEPC;
			endcase
			op = csr_funct3_t'(($unsigned($random(seed)) % 3) + 1);
			if ($random(seed) & 1)
				op[2] = 1'b1;
			value = $random(seed);
			field = 5'($random(seed));
			// Zero rs1 field often enough to reach the no-write case.
			if (($random(seed) & 3) == 0)
				field = 5'd0;
			old_value = model_value(index);
			csr_op(op, index, field, value, rdata, illegal);
			check_value("o_csr_rdata", rdata, old_value);
			check_flag("o_csr_illegal", illegal, 1'b0);
			if (writes(op, field))
				set_model(index, apply_op(op, old_value, field, value));
		end
		expect_csr("mstatus", `CSR_MSTATUS, model_mstatus);
		expect_csr("mie", `CSR_MIE, model_mie);
		expect_csr("mtvec", `CSR_MTVEC, model_mtvec);
		expect_csr("mepc", `CSR_MEPC, model_mepc);
	endtask

	task automatic identity_access();
		expect_csr("mvendorid", `CSR_MVENDORID, `DEF_VENDORID);
		expect_csr("marchid", `CSR_MARCHID, `DEF_ARCHID);
		expect_csr("mimpid", `CSR_MIMPID, `DEF_IMPID);
		expect_csr("mhartid", `CSR_MHARTID, `DEF_HARTID);
		expect_illegal(`FUNCT3_CSRRW, `CSR_MHARTID);
		expect_illegal(`FUNCT3_CSRRS, `CSR_MIMPID);
		expect_illegal(`FUNCT3_CSRRS, 12'h7C0);
		expect_illegal(`FUNCT3_CSRRW, 12'h345);
		expect_csr("mhartid", `CSR_MHARTID, `DEF_HARTID);
		expect_csr("mimpid", `CSR_MIMPID, `DEF_IMPID);
		expect_csr("mstatus", `CSR_MSTATUS, model_mstatus);
		expect_csr("mie", `CSR_MIE, model_mie);
		expect_csr("mtvec", `CSR_MTVEC, model_mtvec);
		expect_csr("mepc", `CSR_MEPC, model_mepc);
		expect_csr("mcause", `CSR_MCAUSE, 32'd0);
		expect_csr("mip", `CSR_MIP, 32'd0);
	endtask

	task automatic masked_requests(csr_word_t mstatus_value, csr_word_t mie_value);
		write_csr(`CSR_MSTATUS, mstatus_value);
		write_csr(`CSR_MIE, mie_value);
		drive_requests(3'b111);
		repeat (4) begin
			@(negedge i_clock);
			check_flag("o_irq_pending", o_irq_pending, 1'b0);
		end
		drive_requests(3'b000);
		repeat (3) begin
			@(negedge i_clock);
			check_flag("o_irq_pending", o_irq_pending, 1'b0);
		end
		expect_csr("mip", `CSR_MIP, 32'd0);
	endtask

	task automatic trap_priority();
		write_csr(`CSR_MTVEC, $random(seed) & 32'hFFFF_FFFC);
		write_csr(`CSR_MIE, 32'h0000_0888);
		write_csr(`CSR_MSTATUS, 32'h0000_0008);
		// An isolated request goes pending two edges after it is driven.
		drive_requests(3'b010);
		drive_requests(3'b000);
		@(negedge i_clock);
		check_flag("o_irq_pending", o_irq_pending, 1'b0);
		@(negedge i_clock);
		check_flag("o_irq_pending", o_irq_pending, 1'b1);
		take_trap(`CAUSE_TIMER);
		drive_requests(3'b111);
		drive_requests(3'b000);
		take_trap(`CAUSE_TIMER);
		take_trap(`CAUSE_EXTERNAL);
		take_trap(`CAUSE_ECALL);
		expect_csr("mip", `CSR_MIP, 32'd0);
	endtask

	task automatic dispatch_hold();
		csr_word_t first_pc;
		first_pc = $random(seed);
		drive_requests(3'b010);
		drive_requests(3'b000);
		wait_pending();
		// External request arrives while the timer trap is pending.
		drive_requests(3'b100);
		drive_requests(3'b000);
		i_irq_dispatched <= 1'b1;
		i_irq_epc <= first_pc;
		@(posedge i_clock);
		@(negedge i_clock);
		check_flag("o_irq_pending", o_irq_pending, 1'b0);
		check_value("o_epc", o_epc, first_pc);
		model_mepc = first_pc;
		wait_pending();
		expect_csr("mcause", `CSR_MCAUSE, `CAUSE_EXTERNAL);
		repeat (3) begin
			@(negedge i_clock);
			check_flag("o_irq_pending", o_irq_pending, 1'b1);
		end
		check_value("o_epc", o_epc, first_pc);
		@(posedge i_clock);
		i_irq_dispatched <= 1'b0;
		take_trap(`CAUSE_EXTERNAL);
		expect_csr("mip", `CSR_MIP, 32'd0);
	endtask

	initial begin
		int failures;
		seed = 32'h36c5_d05e;
		i_reset = 1'b1;
		i_timer_interrupt = 1'b0;
		i_external_interrupt = 1'b0;
		i_ecall = 1'b0;
		i_csr_valid = 1'b0;
		i_csr_funct3 = '0;
		i_csr_index = '0;
		i_rs1_field = '0;
		i_rs1_value = '0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = '0;
		model_mstatus = '0;
		model_mie = '0;
		model_mtvec = '0;
		model_mepc = '0;
		repeat (3) @(posedge i_clock);
		i_reset <= 1'b0;

		random_ops();
		report_test(1, "random CSR operations");
		identity_access();
		report_test(2, "identity and illegal access");
		masked_requests(32'h0000_0000, 32'h0000_0888);
		masked_requests(32'h0000_0008, 32'h0000_0000);
		report_test(3, "masked requests");
		trap_priority();
		report_test(4, "trap priority and cause");
		dispatch_hold();
		report_test(5, "dispatch completion");

		failures = errors + uut.chk.fail_count;
		$display("Tests 5, checks %0d, failures %0d, assertion failures %0d",
			checks, errors, uut.chk.fail_count);
		if (failures == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: csr_unit.f
+incdir+source
source/csr_pkg.sv
source/csr_access_if.sv
source/csr_trap_if.sv
source/csr_op_unit.sv
source/csr_file.sv
source/irq_controller.sv
source/csr_unit.sv
testbench/csr_unit_chk.sv
testbench/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module csr_unit_tb -Mdir obj_dir -f csr_unit.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcsr_unit_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
